// ==== dv/pdp_core_tests.svh ====
/* directed tests and reference model for the pooling input path;
   included into the testbench module body */

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  // open window and running layer counts
  int        win_cnt = 0;
  pdp_data_t win_acc = '0;
  count32_t  run_nan = '0;
  count32_t  run_inf = '0;
  // finished layers with the oldest first
  count32_t  layer_nan_q[$];
  count32_t  layer_inf_q[$];

  // exponent all ones and mantissa not zero
  function automatic logic ref_nan(input fp16_t e);
    return (e[14:10] == 5'h1f) && (e[9:0] != 10'h0);
  endfunction

  function automatic logic ref_inf(input fp16_t e);
    return (e[14:10] == 5'h1f) && (e[9:0] == 10'h0);
  endfunction

  // a above b in value with -0 below +0
  function automatic logic ref_above(input fp16_t a, input fp16_t b);
    if (a[15] != b[15]) return b[15];
    if (!a[15]) return a[14:0] > b[14:0];
    return a[14:0] < b[14:0];
  endfunction

  // queue one beat and predict its effect under the current config
  task automatic add_beat(input pdp_data_t data, input pdp_info_t info);
    pdp_data_t zd;
    fp16_t     e;
    fp16_t     a;
    logic      take;
    stim_q.push_back({info, data});
    zd = data;
    for (int i = 0; i < `PDP_THROUGHPUT; i++) begin
      e = data[i*`PDP_BWPE +: `PDP_BWPE];
      // counted before zeroing
      run_nan = run_nan + ref_nan(e);
      run_inf = run_inf + ref_inf(e);
      if (ref_nan(e) && reg2dp_nan_to_zero) zd[i*`PDP_BWPE +: `PDP_BWPE] = '0;
      e = zd[i*`PDP_BWPE +: `PDP_BWPE];
      a = win_acc[i*`PDP_BWPE +: `PDP_BWPE];
      take = (reg2dp_pooling_method == POOL_MAX) ? ref_above(e, a) : ref_above(a, e);
      if (win_cnt == 0 || take) win_acc[i*`PDP_BWPE +: `PDP_BWPE] = e;
    end
    win_cnt++;
    // window closes on width or line end
    if (win_cnt == reg2dp_kernel_width || info[`PDP_INFO_LINE_END]) begin
      exp_q.push_back({info, win_acc});
      win_cnt = 0;
    end
    if (info[`PDP_INFO_SURF_END] && info[`PDP_INFO_CUBE_END]) begin
      layer_nan_q.push_back(run_nan);
      layer_inf_q.push_back(run_inf);
      run_nan = '0;
      run_inf = '0;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  // exponent kept below all ones
  function automatic fp16_t rand_normal();
    fp16_t e;
    e = rand_bits(16);
    if (e[14:10] == 5'h1f) e[14] = 1'b0;
    return e;
  endfunction

  // about half nan or inf
  function automatic fp16_t rand_special();
    fp16_t      e;
    logic [1:0] kind;
    kind = 2'(rand_bits(2));
    e = rand_normal();
    if (kind == 2'd0) e = {e[15], 5'h1f, e[9:1], 1'b1};
    else if (kind == 2'd1) e = {e[15], 5'h1f, 10'h0};
    return e;
  endfunction

  function automatic pdp_data_t rand_data(input logic special);
    pdp_data_t d;
    for (int i = 0; i < `PDP_THROUGHPUT; i++) begin
      d[i*`PDP_BWPE +: `PDP_BWPE] = special ? rand_special() : rand_normal();
    end
    return d;
  endfunction

  // line end as asked and never a layer end
  function automatic pdp_info_t rand_info(input logic line_end);
    pdp_info_t info;
    info = pdp_info_t'(rand_bits(`PDP_INFO_W));
    info[`PDP_INFO_SURF_END] = 1'b0;
    info[`PDP_INFO_CUBE_END] = 1'b0;
    info[`PDP_INFO_LINE_END] = line_end;
    return info;
  endfunction

  // send all queued beats then compare the outputs in order
  task automatic run_beats(input string name);
    while (stim_q.size() > 0) send_beat(stim_q.pop_front());
    while (rx_q.size() < exp_q.size()) next_cycle();
    // room for extra beats to show up
    repeat (5) next_cycle();
    if (rx_q.size() != exp_q.size()) begin
      flag_error($sformatf("%s: got %0d output beats, expected %0d",
                           name, rx_q.size(), exp_q.size()));
    end
    while (rx_q.size() > 0 && exp_q.size() > 0) begin
      compare_value(name, exp_q.pop_front(), rx_q.pop_front());
    end
    rx_q.delete();
    exp_q.delete();
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  task automatic test_gate();
    reg2dp_kernel_width = 3'd1;
    for (int i = 0; i < 4; i++) add_beat(rand_data(1'b0), rand_info(1'b1));
    // beat offered while op_en is still low
    pdp_rdma2dp_valid = 1'b1;
    pdp_rdma2dp_pd    = stim_q[0];
    repeat (20) begin
      @(negedge nvdla_core_clk);
      if (pdp_rdma2dp_ready) flag_error("gate: input ready high before op_en rose");
    end
    if (rx_q.size() != 0) flag_error("gate: output beat appeared before op_en rose");
    next_cycle();
    reg2dp_op_en = 1'b1;
    run_beats("gate");
    finish_test("gate");
  endtask

  task automatic test_passthrough();
    reg2dp_kernel_width = 3'd1;
    reg2dp_nan_to_zero  = 1'b0;
    for (int i = 0; i < 16; i++) add_beat(rand_data(1'b1), rand_info(lfsr_bit()));
    run_beats("passthrough");
    finish_test("passthrough");
  endtask

  task automatic test_nan_zero();
    reg2dp_kernel_width = 3'd1;
    reg2dp_nan_to_zero  = 1'b1;
    for (int i = 0; i < 16; i++) add_beat(rand_data(1'b1), rand_info(lfsr_bit()));
    run_beats("nan_zero");
    reg2dp_nan_to_zero = 1'b0;
    finish_test("nan_zero");
  endtask

  task automatic test_pooling();
    reg2dp_kernel_width   = 3'd3;
    reg2dp_pooling_method = POOL_MAX;
    // last beat closes the final window
    for (int i = 0; i < 24; i++) begin
      add_beat(rand_data(1'b0), rand_info((rand_bits(2) == 16'd0) || (i == 23)));
    end
    run_beats("pool_max");
    reg2dp_pooling_method = POOL_MIN;
    for (int i = 0; i < 24; i++) begin
      add_beat(rand_data(1'b0), rand_info((rand_bits(2) == 16'd0) || (i == 23)));
    end
    run_beats("pool_min");
    finish_test("pooling");
  endtask

  task automatic test_backpressure();
    reg2dp_kernel_width   = 3'd2;
    reg2dp_pooling_method = POOL_MAX;
    for (int i = 0; i < 32; i++) begin
      add_beat(rand_data(1'b0), rand_info((rand_bits(3) == 16'd0) || (i == 31)));
    end
    set_random_ready(1'b1);
    run_beats("backpressure");
    set_random_ready(1'b0);
    finish_test("backpressure");
  endtask

  task automatic test_layer_stats();
    pdp_info_t info;
    reg2dp_kernel_width = 3'd1;
    compare_value("stats_reset", '0, dp2reg_nan_input_num);
    compare_value("stats_reset", '0, dp2reg_inf_input_num);
    // layer 1 also holds every beat of the earlier tests
    for (int i = 0; i < 8; i++) begin
      info = rand_info(1'b1);
      info[`PDP_INFO_SURF_END] = (i == 7);
      info[`PDP_INFO_CUBE_END] = (i == 7);
      add_beat(rand_data(1'b1), info);
    end
    run_beats("layer1");
    repeat (10) begin
      @(negedge nvdla_core_clk);
      if (pdp_rdma2dp_ready) flag_error("layer_stats: input ready high after layer end");
    end
    next_cycle();
    // op_en low for one cycle before a fresh rising edge
    reg2dp_op_en = 1'b0;
    next_cycle();
    reg2dp_op_en = 1'b1;
    for (int i = 0; i < 8; i++) begin
      info = rand_info(1'b1);
      info[`PDP_INFO_SURF_END] = (i == 7);
      info[`PDP_INFO_CUBE_END] = (i == 7);
      add_beat(rand_data(1'b1), info);
    end
    run_beats("layer2");
    repeat (3) next_cycle();
    while (layer_nan_q.size() > 0) begin
      dp2reg_done = 1'b1;
      next_cycle();
      dp2reg_done = 1'b0;
      compare_value("stats_nan", layer_nan_q.pop_front(), dp2reg_nan_input_num);
      compare_value("stats_inf", layer_inf_q.pop_front(), dp2reg_inf_input_num);
      next_cycle();
    end
    finish_test("layer_stats");
  endtask

// ==== dv/pdp_core_tb.sv ====
/* testbench for the pooling input path; clock, reset, stimulus driving,
   output monitor and test order, with the tests in the included file */
`include "pdp_macros.svh"
`default_nettype none

module pdp_core_tb
  import pdp_types_pkg::*;
  import pdp_cfg_pkg::*;
  ();

  // beats over all tests, sets the run limit
  localparam int TOTAL_BEATS = 4 + 16 + 16 + 48 + 32 + 16;
  localparam int CYCLE_LIMIT = 40 * TOTAL_BEATS + 200;

  logic                 nvdla_core_clk;
  logic                 nvdla_core_rstn;
  logic                 reg2dp_op_en;
  logic                 reg2dp_nan_to_zero;
  pool_method_e         reg2dp_pooling_method;
  kernel_width_t        reg2dp_kernel_width;
  logic                 dp2reg_done;
  count32_t             dp2reg_nan_input_num;
  count32_t             dp2reg_inf_input_num;
  logic                 pdp_rdma2dp_valid;
  logic [`PDP_PD_W-1:0] pdp_rdma2dp_pd;
  logic                 pdp_rdma2dp_ready;
  logic                 pdp_dp2wdma_valid;
  logic [`PDP_PD_W-1:0] pdp_dp2wdma_pd;
  logic                 pdp_dp2wdma_ready;

  logic [15:0]          lfsr;
  logic                 random_ready;
  int                   cycles;
  int                   checks;
  int                   errors;
  int                   test_errors;
  int                   tests_run;
  // beats to send, beats expected, beats seen
  logic [`PDP_PD_W-1:0] stim_q[$];
  logic [`PDP_PD_W-1:0] exp_q[$];
  logic [`PDP_PD_W-1:0] rx_q[$];

  pdp_core i_dut (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #10 nvdla_core_clk = ~nvdla_core_clk;
  end

  //////////////////////////////////////////////////
  // random source
  //////////////////////////////////////////////////
  // galois lfsr, x^16+x^14+x^13+x^11+1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 16'hB400;
    return b;
  endfunction

  // n fresh bits, one step each
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_bit()};
    end
    return v;
  endfunction

  //////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////
  task automatic compare_value(input string name, input logic [`PDP_PD_W-1:0] exp,
                               input logic [`PDP_PD_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic flag_error(input string msg);
    errors++;
    test_errors++;
    $display("%s", msg);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s done, no errors", name);
    end else begin
      $display("test %s done, %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////
  // driving
  //////////////////////////////////////////////////
  // inputs move 2 units after the rising edge
  task automatic next_cycle();
    @(posedge nvdla_core_clk);
    #2;
  endtask

  // hold the beat until the gate/nan stage takes it
  task automatic send_beat(input logic [`PDP_PD_W-1:0] pd);
    pdp_rdma2dp_valid = 1'b1;
    pdp_rdma2dp_pd    = pd;
    @(negedge nvdla_core_clk);
    while (!pdp_rdma2dp_ready) @(negedge nvdla_core_clk);
    next_cycle();
    pdp_rdma2dp_valid = 1'b0;
  endtask

  // switched at the falling edge, away from the ready driver
  task automatic set_random_ready(input logic on);
    @(negedge nvdla_core_clk);
    random_ready = on;
    next_cycle();
  endtask

  // write side ready, random in the back-pressure test
  always @(posedge nvdla_core_clk) begin
    #2;
    if (random_ready) begin
      pdp_dp2wdma_ready = lfsr_bit();
    end else begin
      pdp_dp2wdma_ready = 1'b1;
    end
  end

  // beat leaves on the next rising edge
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn && pdp_dp2wdma_valid && pdp_dp2wdma_ready) begin
      rx_q.push_back(pdp_dp2wdma_pd);
    end
  end

  always @(posedge nvdla_core_clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  `include "pdp_core_tests.svh"

  //////////////////////////////////////////////////
  // test order
  //////////////////////////////////////////////////
  initial begin
    nvdla_core_rstn       = 1'b0;
    reg2dp_op_en          = 1'b0;
    reg2dp_nan_to_zero    = 1'b0;
    reg2dp_pooling_method = POOL_MAX;
    reg2dp_kernel_width   = 3'd1;
    dp2reg_done           = 1'b0;
    pdp_rdma2dp_valid     = 1'b0;
    pdp_rdma2dp_pd        = '0;
    pdp_dp2wdma_ready     = 1'b1;
    random_ready          = 1'b0;
    lfsr                  = 16'd45882;
    cycles                = 0;
    checks                = 0;
    errors                = 0;
    test_errors           = 0;
    tests_run             = 0;
    repeat (10) @(posedge nvdla_core_clk);
    #2;
    nvdla_core_rstn = 1'b1;
    next_cycle();
    test_gate();
    test_passthrough();
    test_nan_zero();
    test_pooling();
    test_backpressure();
    test_layer_stats();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/pdp_beat_if.sv ====
/* one beat between pipeline stages, valid/ready handshake;
   transfer when both high, payload held while valid and not ready */
`default_nettype none

interface pdp_beat_if
  import pdp_types_pkg::*;
  ();

  logic      valid;
  logic      ready;
  pdp_data_t data;
  pdp_info_t info;

  // producer side
  modport src (
    output valid, data, info,
    input  ready
  );

  // consumer side
  modport dst (
    input  valid, data, info,
    output ready
  );

endinterface

`default_nettype wire

// ==== logic/pdp_cfg_pkg.sv ====
/* register-side types for the pooling input path:
   pooling method, kernel width and the op-enable gate states */
`default_nettype none

package pdp_cfg_pkg;

  // one bit, matches the register field
  typedef enum logic {
    POOL_MAX = 1'b0,
    POOL_MIN = 1'b1
  } pool_method_e;

  // window length in beats, 1..7, zero not allowed
  typedef logic [2:0] kernel_width_t;

  // layer gating in the first stage
  typedef enum logic {
    GATE_WAIT = 1'b0,
    GATE_RUN  = 1'b1
  } gate_state_e;

endpackage

`default_nettype wire

// ==== logic/pdp_core.sv ====
/* pooling input path top: op_en gate and nan stage, layer counters
   and 1d max/min pooling, joined by interfaces, plain ports outside */
`include "pdp_macros.svh"
`default_nettype none

module pdp_core
  import pdp_types_pkg::*;
  import pdp_cfg_pkg::*;
(
  input  logic                 nvdla_core_clk,
  input  logic                 nvdla_core_rstn,
  // register side
  input  logic                 reg2dp_op_en,
  input  logic                 reg2dp_nan_to_zero,
  input  pool_method_e         reg2dp_pooling_method,
  input  kernel_width_t        reg2dp_kernel_width,
  input  logic                 dp2reg_done,
  output count32_t             dp2reg_nan_input_num,
  output count32_t             dp2reg_inf_input_num,
  // from read dma
  input  logic                 pdp_rdma2dp_valid,
  input  logic [`PDP_PD_W-1:0] pdp_rdma2dp_pd,
  output logic                 pdp_rdma2dp_ready,
  // to write dma
  output logic                 pdp_dp2wdma_valid,
  output logic [`PDP_PD_W-1:0] pdp_dp2wdma_pd,
  input  logic                 pdp_dp2wdma_ready
);

  // nan stage to pooling
  pdp_beat_if     nan2pool ();
  // nan stage to counters
  pdp_nan_stat_if nan_stat ();

  pdp_nan u_nan (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .reg2dp_op_en       (reg2dp_op_en),
    .reg2dp_nan_to_zero (reg2dp_nan_to_zero),
    .in_valid           (pdp_rdma2dp_valid),
    .in_pd              (pdp_rdma2dp_pd),
    .in_ready           (pdp_rdma2dp_ready),
    .out                (nan2pool.src),
    .stat               (nan_stat.src)
  );

  pdp_nan_count u_nan_count (
    .nvdla_core_clk       (nvdla_core_clk),
    .nvdla_core_rstn      (nvdla_core_rstn),
    .stat                 (nan_stat.dst),
    .dp2reg_done          (dp2reg_done),
    .dp2reg_nan_input_num (dp2reg_nan_input_num),
    .dp2reg_inf_input_num (dp2reg_inf_input_num)
  );

  pdp_pool_1d u_pool_1d (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .reg2dp_pooling_method (reg2dp_pooling_method),
    .reg2dp_kernel_width   (reg2dp_kernel_width),
    .in                    (nan2pool.dst),
    .out_valid             (pdp_dp2wdma_valid),
    .out_pd                (pdp_dp2wdma_pd),
    .out_ready             (pdp_dp2wdma_ready)
  );

endmodule

`default_nettype wire

// ==== logic/pdp_macros.svh ====
/* widths and info bit positions for the pooling input path;
   included by every file that sizes a beat or decodes its info field */
`ifndef PDP_MACROS_SVH
`define PDP_MACROS_SVH

// bits per element, fp16
`define PDP_BWPE 16

// elements per beat
`define PDP_THROUGHPUT 4

// position info carried above the data
`define PDP_INFO_W 12

// full beat, info on top of data
`define PDP_PD_W (`PDP_BWPE * `PDP_THROUGHPUT + `PDP_INFO_W)

// info bits, counted from info bit 0
// surface end and cube end together mark the last beat of a layer
`define PDP_INFO_SURF_END 11
`define PDP_INFO_CUBE_END 7
`define PDP_INFO_LINE_END 4

`endif

// ==== logic/pdp_nan.sv ====
/* first stage: holds each layer until op_en rises, zeroes nan elements
   on request, counts nan/inf per beat and registers the beat once */
`include "pdp_macros.svh"
`default_nettype none

module pdp_nan
  import pdp_types_pkg::*;
  import pdp_cfg_pkg::*;
(
  input  logic                 nvdla_core_clk,
  input  logic                 nvdla_core_rstn,
  input  logic                 reg2dp_op_en,
  input  logic                 reg2dp_nan_to_zero,
  input  logic                 in_valid,
  input  logic [`PDP_PD_W-1:0] in_pd,
  output logic                 in_ready,
  pdp_beat_if.src              out,
  pdp_nan_stat_if.src          stat
);

  gate_state_e                gate_state;
  gate_state_e                gate_next;
  logic                       op_en_d1;
  logic                       op_en_rise;
  logic                       load;
  logic                       layer_end;
  pdp_data_t                  in_data;
  pdp_info_t                  in_info;
  pdp_data_t                  zero_data;
  logic [`PDP_THROUGHPUT-1:0] is_nan;
  logic [`PDP_THROUGHPUT-1:0] is_inf;
  elem_cnt_t                  nan_sum;
  elem_cnt_t                  inf_sum;
  logic                       dout_vld;
  pdp_data_t                  dout_data;
  pdp_info_t                  dout_info;

  assign in_data = in_pd[`PDP_BWPE*`PDP_THROUGHPUT-1:0];
  assign in_info = in_pd[`PDP_PD_W-1:`PDP_BWPE*`PDP_THROUGHPUT];

  //////////////////////////////////////////////////
  // op_en gating
  //////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_d1 <= 1'b0;
    end else begin
      op_en_d1 <= reg2dp_op_en;
    end
  end
  assign op_en_rise = reg2dp_op_en & ~op_en_d1;

  // last beat of layer: surface end and cube end both set
  assign layer_end = load & in_info[`PDP_INFO_SURF_END] & in_info[`PDP_INFO_CUBE_END];

  always_comb begin
    gate_next = gate_state;
    case (gate_state)
      GATE_WAIT: if (op_en_rise) gate_next = GATE_RUN;
      GATE_RUN:  if (layer_end) gate_next = GATE_WAIT;
      default:   gate_next = GATE_WAIT;
    endcase
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      gate_state <= GATE_WAIT;
    end else begin
      gate_state <= gate_next;
    end
  end

  // take a beat when running and output slot free or draining
  assign in_ready = (gate_state == GATE_RUN) & (~dout_vld | out.ready);
  assign load     = in_valid & in_ready;

  //////////////////////////////////////////////////
  // classify and zero per element
  //////////////////////////////////////////////////
  for (genvar i = 0; i < `PDP_THROUGHPUT; i++) begin : g_elem
    fp16_t elem;
    assign elem      = in_data[i*`PDP_BWPE +: `PDP_BWPE];
    assign is_nan[i] = fp16_is_nan(elem);
    assign is_inf[i] = fp16_is_inf(elem);
    // inf passes through untouched
    assign zero_data[i*`PDP_BWPE +: `PDP_BWPE] =
      (is_nan[i] & reg2dp_nan_to_zero) ? '0 : elem;
  end

  // counts from raw input, before zeroing
  always_comb begin
    nan_sum = '0;
    inf_sum = '0;
    for (int i = 0; i < `PDP_THROUGHPUT; i++) begin
      nan_sum = nan_sum + elem_cnt_t'(is_nan[i]);
      inf_sum = inf_sum + elem_cnt_t'(is_inf[i]);
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dout_vld <= 1'b0;
    end else if (load) begin
      dout_vld <= 1'b1;
    end else if (out.ready) begin
      dout_vld <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      dout_data <= zero_data;
      dout_info <= in_info;
    end
  end

  assign out.valid = dout_vld;
  assign out.data  = dout_data;
  assign out.info  = dout_info;

  // stat strobe, one cycle per accepted beat
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stat.stat_vld <= 1'b0;
    end else begin
      stat.stat_vld <= load;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      stat.nan_num   <= nan_sum;
      stat.inf_num   <= inf_sum;
      stat.layer_end <= layer_end;
    end
  end

  // after a layer ends nothing enters before the next op_en edge
  a_hold_after_layer: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    layer_end |=> (!in_ready until_with op_en_rise)
  );

  // stalled beat keeps its payload
  a_out_stable: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (out.valid && !out.ready) |=> (out.valid && $stable(out.data) && $stable(out.info))
  );

endmodule

`default_nettype wire

// ==== logic/pdp_nan_count.sv ====
/* per-layer nan and inf input counters; finished layers wait in a
   two-entry store and each dp2reg_done publishes the oldest one */
`default_nettype none

module pdp_nan_count
  import pdp_types_pkg::*;
(
  input  logic          nvdla_core_clk,
  input  logic          nvdla_core_rstn,
  pdp_nan_stat_if.dst   stat,
  input  logic          dp2reg_done,
  output count32_t      dp2reg_nan_input_num,
  output count32_t      dp2reg_inf_input_num
);

  count32_t   nan_in_count;
  count32_t   inf_in_count;
  count32_t   nan_total;
  count32_t   inf_total;
  count32_t   nan_in_num0;
  count32_t   nan_in_num1;
  count32_t   inf_in_num0;
  count32_t   inf_in_num1;
  logic       layer_wr;
  logic       rd_en;
  logic       wr_flag;
  logic       rd_flag;
  logic [1:0] pending;

  // running totals incl. the current beat
  assign nan_total = nan_in_count + count32_t'(stat.nan_num);
  assign inf_total = inf_in_count + count32_t'(stat.inf_num);
  assign layer_wr  = stat.stat_vld & stat.layer_end;

  //////////////////////////////////////////////////
  // running counts
  //////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      nan_in_count <= '0;
      inf_in_count <= '0;
    end else if (stat.stat_vld) begin
      // restart at layer end
      nan_in_count <= stat.layer_end ? '0 : nan_total;
      inf_in_count <= stat.layer_end ? '0 : inf_total;
    end
  end

  //////////////////////////////////////////////////
  // two-entry layer store, ping-pong slots
  //////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk) begin
    if (layer_wr) begin
      if (wr_flag) begin
        nan_in_num1 <= nan_total;
        inf_in_num1 <= inf_total;
      end else begin
        nan_in_num0 <= nan_total;
        inf_in_num0 <= inf_total;
      end
    end
  end

  // done with an empty store is ignored
  assign rd_en = dp2reg_done & (pending != 2'd0);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_flag <= 1'b0;
      rd_flag <= 1'b0;
      pending <= 2'd0;
    end else begin
      if (layer_wr) wr_flag <= ~wr_flag;
      if (rd_en) rd_flag <= ~rd_flag;
      pending <= pending + {1'b0, layer_wr} - {1'b0, rd_en};
    end
  end

  // publish oldest layer
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dp2reg_nan_input_num <= '0;
      dp2reg_inf_input_num <= '0;
    end else if (rd_en) begin
      dp2reg_nan_input_num <= rd_flag ? nan_in_num1 : nan_in_num0;
      dp2reg_inf_input_num <= rd_flag ? inf_in_num1 : inf_in_num0;
    end
  end

  // a third layer would overwrite an unread result
  a_store_overflow: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(layer_wr && (pending == 2'd2) && !rd_en)
  );

endmodule

`default_nettype wire

// ==== logic/pdp_nan_stat_if.sv ====
/* per-beat nan/inf counts from the first stage to the layer counters;
   one-cycle strobe per accepted beat, no back-pressure */
`default_nettype none

interface pdp_nan_stat_if
  import pdp_types_pkg::*;
  ();

  logic      stat_vld;
  elem_cnt_t nan_num;
  elem_cnt_t inf_num;
  // beat closes the layer
  logic      layer_end;

  modport src (
    output stat_vld, nan_num, inf_num, layer_end
  );

  modport dst (
    input  stat_vld, nan_num, inf_num, layer_end
  );

endinterface

`default_nettype wire

// ==== logic/pdp_pool_1d.sv ====
/* second stage: elementwise max or min over kernel_width beats along
   a line; a line-end beat closes the window early */
`include "pdp_macros.svh"
`default_nettype none

module pdp_pool_1d
  import pdp_types_pkg::*;
  import pdp_cfg_pkg::*;
(
  input  logic                 nvdla_core_clk,
  input  logic                 nvdla_core_rstn,
  input  pool_method_e         reg2dp_pooling_method,
  input  kernel_width_t        reg2dp_kernel_width,
  pdp_beat_if.dst              in,
  output logic                 out_valid,
  output logic [`PDP_PD_W-1:0] out_pd,
  input  logic                 out_ready
);

  kernel_width_t beat_cnt;
  kernel_width_t cnt_next;
  logic          win_first;
  logic          load;
  logic          close;
  pdp_data_t     acc_data;
  pdp_data_t     merged;
  logic          dout_vld;
  pdp_data_t     dout_data;
  pdp_info_t     dout_info;

  //////////////////////////////////////////////////
  // handshake and window control
  //////////////////////////////////////////////////
  assign in.ready = ~dout_vld | out_ready;
  assign load     = in.valid & in.ready;

  // beats already folded into the window
  assign win_first = (beat_cnt == '0);
  assign cnt_next  = beat_cnt + kernel_width_t'(1);

  // kernel-width-th beat or line end
  assign close = load & ((cnt_next == reg2dp_kernel_width) | in.info[`PDP_INFO_LINE_END]);

  //////////////////////////////////////////////////
  // elementwise compare on order keys
  //////////////////////////////////////////////////
  for (genvar i = 0; i < `PDP_THROUGHPUT; i++) begin : g_elem
    fp16_t acc_e;
    fp16_t in_e;
    logic  take_in;
    assign acc_e = acc_data[i*`PDP_BWPE +: `PDP_BWPE];
    assign in_e  = in.data[i*`PDP_BWPE +: `PDP_BWPE];
    assign take_in = (reg2dp_pooling_method == POOL_MAX) ?
                     (fp16_order_key(in_e) > fp16_order_key(acc_e)) :
                     (fp16_order_key(in_e) < fp16_order_key(acc_e));
    // first beat of window seeds the accumulator
    assign merged[i*`PDP_BWPE +: `PDP_BWPE] = (win_first | take_in) ? in_e : acc_e;
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beat_cnt <= '0;
    end else if (close) begin
      beat_cnt <= '0;
    end else if (load) begin
      beat_cnt <= cnt_next;
    end
  end

  // running elements, only meaningful while beat_cnt != 0
  always_ff @(posedge nvdla_core_clk) begin
    if (load && !close) begin
      acc_data <= merged;
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dout_vld <= 1'b0;
    end else if (close) begin
      dout_vld <= 1'b1;
    end else if (out_ready) begin
      dout_vld <= 1'b0;
    end
  end

  // pooled beat carries the closing beat's info
  always_ff @(posedge nvdla_core_clk) begin
    if (close) begin
      dout_data <= merged;
      dout_info <= in.info;
    end
  end

  assign out_valid = dout_vld;
  assign out_pd    = {dout_info, dout_data};

  // legal width, and the window never runs past it
  a_kernel_width: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    load |-> ((reg2dp_kernel_width != '0) && (beat_cnt < reg2dp_kernel_width))
  );

endmodule

`default_nettype wire

// ==== logic/pdp_types_pkg.sv ====
/* datapath types and fp16 helpers shared by the pooling stages;
   classify for nan/inf stats, order key for max/min compare */
`include "pdp_macros.svh"
`default_nettype none

package pdp_types_pkg;

  typedef logic [`PDP_BWPE-1:0]                   fp16_t;
  // element 0 in the low bits
  typedef logic [`PDP_BWPE*`PDP_THROUGHPUT-1:0]   pdp_data_t;
  typedef logic [`PDP_INFO_W-1:0]                 pdp_info_t;
  // 0..4 hits per beat
  typedef logic [2:0]                             elem_cnt_t;
  typedef logic [31:0]                            count32_t;

  // exp all ones, mantissa nonzero
  function automatic logic fp16_is_nan(input fp16_t x);
    return (&x[14:10]) & (|x[9:0]);
  endfunction

  // exp all ones, mantissa zero
  function automatic logic fp16_is_inf(input fp16_t x);
    return (&x[14:10]) & ~(|x[9:0]);
  endfunction

  // unsigned compare of keys follows fp value for non-nan inputs
  // negatives flipped entirely, positives get the top bit set
  // so -0 (0x8000) maps below +0 (0x0000)
  function automatic fp16_t fp16_order_key(input fp16_t x);
    fp16_t key;
    if (x[`PDP_BWPE-1]) begin
      key = ~x;
    end else begin
      key = {1'b1, x[`PDP_BWPE-2:0]};
    end
    return key;
  endfunction

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+logic
+incdir+dv
logic/pdp_types_pkg.sv
logic/pdp_cfg_pkg.sv
logic/pdp_beat_if.sv
logic/pdp_nan_stat_if.sv
logic/pdp_nan.sv
logic/pdp_nan_count.sv
logic/pdp_pool_1d.sv
logic/pdp_core.sv
dv/pdp_core_tb.sv
